/* Makefile */
# verilator build and run of the rv_core commit monitor
OBJ = obj_dir
BIN = $(OBJ)/Vrv_core_tb

all: run

$(BIN): tb.f rv_pkg.sv rv_regfile.sv rv_decode.sv rv_execute.sv rv_result.sv rv_core.sv rv_core_tb.sv
	verilator --binary --timing --assert -f tb.f --top-module rv_core_tb --Mdir $(OBJ) -o Vrv_core_tb

run: $(BIN) rv_stimulus.txt
	$(BIN) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all run clean

/* rv_core.sv */
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     instr,
    input  logic            instr_valid,
    output logic [xlen-1:0] fetch_pc,
    output logic            commit_valid,
    output commit_t         commit
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    dec_ctrl_t       dec;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    exe_out_t        exe_comb;
    exe_out_t        exe_q;
    exe_out_t        res_fwd;
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [xlen-1:0] wr_data;

    // pc, decode and operand select
    rv_decode rv_decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rf_rs1_data (rs1_data),
        .rf_rs2_data (rs2_data),
        .exe_fwd     (exe_comb),
        .res_fwd     (res_fwd),
        .fetch_pc    (fetch_pc),
        .rf_rs1_addr (rs1_addr),
        .rf_rs2_addr (rs2_addr),
        .dec         (dec),
        .op_a        (op_a),
        .op_b        (op_b)
    );

    rv_regfile rv_regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // alu and branch resolve
    rv_execute rv_execute_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .dec         (dec),
        .op_a        (op_a),
        .op_b        (op_b),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .exe_comb    (exe_comb),
        .exe_q       (exe_q)
    );

    // write-back and commit
    rv_result rv_result_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .exe_q        (exe_q),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .res_fwd      (res_fwd),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

/* rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb import rv_pkg::*; ();

    logic            clk = 1'b0;
    logic            rst_n;
    logic [31:0]     instr;
    logic            instr_valid;
    logic [xlen-1:0] fetch_pc;
    logic            commit_valid;
    commit_t         commit;

    // program memory, word addressed
    logic [31:0]     prog [256];
    // expected retirements, oldest first
    commit_t         expected [$];
    int              expected_total = 0;
    int              errors = 0;
    int              commits = 0;
    int              stalls = 0;
    int              flushes = 0;
    logic [31:0]     rnd = 32'h5314;
    // first retirement must come from reset_pc
    logic [xlen-1:0] prev_next = reset_pc;
    logic            halted = 1'b0;

    rv_core rv_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .fetch_pc     (fetch_pc),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // instruction source answers fetch_pc at once
    assign instr = prog[fetch_pc[9:2]];

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        logic [7:0]  tag;
        logic [7:0]  ch;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        commit_t     rec;
        // unused words carry opcode 0 and decode as illegal
        for (int i = 0; i < 256; i++) begin
            prog[i] = {i[24:0], 7'b0000000};
        end
        fd = $fopen("rv_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open rv_stimulus.txt");
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            case (tag)
                "P": begin
                    n = $fscanf(fd, "%h %h", f1, f2);
                    prog[f1[9:2]] = f2;
                end
                "C": begin
                    n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    rec          = '0;
                    rec.pc       = f1;
                    rec.next_pc  = f2;
                    rec.rd       = f3[4:0];
                    rec.rd_wdata = f4;
                    expected.push_back(rec);
                end
                // comment line, skip to its end
                default: begin
                    do begin
                        n = $fscanf(fd, "%c", ch);
                    end while (n == 1 && ch != 8'h0a);
                end
            endcase
        end
        $fclose(fd);
        expected_total = expected.size();
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Mismatch time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_commit();
        commit_t     exp;
        logic [31:0] word;
        logic        writes;
        word   = prog[commit.pc[9:2]];
        // branches are the only forms without a destination
        writes = (word[6:0] != 7'b1100011);
        assert (!halted) else begin
            errors++;
            $display("commit at pc %h after the core halted", commit.pc);
        end
        assert (expected.size() != 0) else begin
            errors++;
            $display("commit at pc %h has no expected record left", commit.pc);
        end
        if (expected.size() != 0) begin
            exp = expected.pop_front();
            compare_field("commit.pc", exp.pc, commit.pc);
            compare_field("commit.next_pc", exp.next_pc, commit.next_pc);
            compare_field("commit.instr", word, commit.instr);
            compare_field("commit.rd_write", {31'd0, writes}, {31'd0, commit.rd_write});
            if (writes) begin
                compare_field("commit.rd", {27'd0, exp.rd}, {27'd0, commit.rd});
            end
            compare_field("commit.rd_wdata", exp.rd_wdata, commit.rd_wdata);
        end
        // flushed words leave no gap in the flow
        compare_field("commit.pc vs previous next_pc", prev_next, commit.pc);
        prev_next = commit.next_pc;
        commits++;
        if (commit.next_pc != commit.pc + 32'd4) begin
            flushes++;
        end
        // jump to itself ends the program
        if (commit.next_pc == commit.pc) begin
            halted = 1'b1;
        end
    endtask

    task automatic print_summary();
        $display("errors=%0d commits=%0d stall_cycles=%0d flushes=%0d",
                 errors, commits, stalls, flushes);
    endtask

    // stall level changes 2 ns after the edge
    always @(posedge clk) begin : drive_stalls
        logic run;
        run = rst_n;
        #2;
        if (run) begin
            rnd         = next_random(rnd);
            instr_valid = (rnd[1:0] != 2'b00);
        end
    end

    // outputs settled mid cycle
    always @(negedge clk) begin : watch_commits
        if (rst_n !== 1'b1) begin
            assert (!commit_valid) else begin
                errors++;
                $display("commit_valid high during reset at %0t", $time);
            end
        end else begin
            if (!instr_valid) begin
                stalls++;
            end
            if (commit_valid) begin
                assert (instr_valid) else begin
                    errors++;
                    $display("commit at %0t while instr_valid was low", $time);
                end
                check_commit();
            end
        end
    end

    initial begin : watchdog
        wait (rst_n === 1'b1);
        repeat (expected_total * 8 + 100) @(posedge clk);
        errors++;
        $display("watchdog expired, the program never reached its halt loop");
        print_summary();
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b1;
        load_stimulus();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait (halted);
        // a few more cycles to catch stray commits
        repeat (4) @(negedge clk);
        assert (expected.size() == 0) else begin
            errors++;
            $display("%0d expected commits never retired", expected.size());
        end
        print_summary();
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* rv_decode.sv */
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic [xlen-1:0] rf_rs1_data,
    input  logic [xlen-1:0] rf_rs2_data,
    input  exe_out_t        exe_fwd,
    input  exe_out_t        res_fwd,
    output logic [xlen-1:0] fetch_pc,
    output logic [4:0]      rf_rs1_addr,
    output logic [4:0]      rf_rs2_addr,
    output dec_ctrl_t       dec,
    output logic [xlen-1:0] op_a,
    output logic [xlen-1:0] op_b
);

    logic [xlen-1:0] pc;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            legal;
    logic            exe_hit_a;
    logic            exe_hit_b;
    logic            res_hit_a;
    logic            res_hit_b;

    // pc only moves on advancing cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (instr_valid) begin
            pc <= redirect ? redirect_pc : pc + instr_step;
        end
    end

    assign fetch_pc    = pc;
    assign funct3      = instr[14:12];
    assign funct7      = instr[31:25];
    assign rf_rs1_addr = instr[19:15];
    assign rf_rs2_addr = instr[24:20];

    always_comb begin
        legal         = 1'b1;
        dec.opcode    = op_none;
        dec.alu_op    = alu_add;
        dec.use_imm   = 1'b0;
        dec.rd_write  = 1'b0;
        dec.imm       = '0;
        dec.funct3    = funct3;
        dec.rd        = instr[11:7];
        dec.pc        = pc;
        dec.instr     = instr;
        case (instr[6:0])
            op_lui: begin
                dec.opcode   = op_lui;
                dec.alu_op   = alu_pass_b;
                dec.use_imm  = 1'b1;
                dec.rd_write = 1'b1;
                dec.imm      = {instr[31:12], 12'h000};
            end
            op_imm, op_reg: begin
                dec.opcode   = opcode_e'(instr[6:0]);
                dec.use_imm  = (instr[6:0] == op_imm);
                dec.rd_write = 1'b1;
                dec.imm      = {{20{instr[31]}}, instr[31:20]};
                case (funct3)
                    3'b000: dec.alu_op = (!dec.use_imm && funct7[5]) ? alu_sub : alu_add;
                    3'b001: dec.alu_op = alu_sll;
                    3'b010: dec.alu_op = alu_slt;
                    3'b011: dec.alu_op = alu_sltu;
                    3'b100: dec.alu_op = alu_xor;
                    3'b101: dec.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110: dec.alu_op = alu_or;
                    default: dec.alu_op = alu_and;
                endcase
                // shifts and register forms only allow funct7 0 or 0x20
                if ((!dec.use_imm || funct3 == 3'b001 || funct3 == 3'b101) &&
                    (funct7 & 7'b1011111) != 7'd0) begin
                    legal = 1'b0;
                end
            end
            op_branch: begin
                dec.opcode = op_branch;
                dec.imm    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                // funct3 010 and 011 are unused
                legal      = (funct3[2:1] != 2'b01);
            end
            op_jal: begin
                dec.opcode   = op_jal;
                dec.rd_write = 1'b1;
                dec.imm      = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            dec.opcode   = op_none;
            dec.rd_write = 1'b0;
        end
        // flush the younger word on redirect
        dec.valid = legal && !redirect;
    end

    // forwarding sources, x0 never matches
    assign exe_hit_a = exe_fwd.valid && exe_fwd.rd_write && (exe_fwd.rd != 5'd0) &&
                       (exe_fwd.rd == rf_rs1_addr);
    assign exe_hit_b = exe_fwd.valid && exe_fwd.rd_write && (exe_fwd.rd != 5'd0) &&
                       (exe_fwd.rd == rf_rs2_addr);
    assign res_hit_a = res_fwd.valid && res_fwd.rd_write && (res_fwd.rd != 5'd0) &&
                       (res_fwd.rd == rf_rs1_addr);
    assign res_hit_b = res_fwd.valid && res_fwd.rd_write && (res_fwd.rd != 5'd0) &&
                       (res_fwd.rd == rf_rs2_addr);

    // youngest producer wins
    assign op_a = exe_hit_a ? exe_fwd.result : (res_hit_a ? res_fwd.result : rf_rs1_data);
    assign op_b = exe_hit_b ? exe_fwd.result : (res_hit_b ? res_fwd.result : rf_rs2_data);

endmodule

/* rv_execute.sv */
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  dec_ctrl_t       dec,
    input  logic [xlen-1:0] op_a,
    input  logic [xlen-1:0] op_b,
    output logic            redirect,
    output logic [xlen-1:0] redirect_pc,
    output exe_out_t        exe_comb,
    output exe_out_t        exe_q
);

    dec_ctrl_t       dec_q;
    logic [xlen-1:0] a_q;
    logic [xlen-1:0] b_q;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_out;
    logic            taken;

    // decode to execute register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_q <= '0;
        end else if (instr_valid) begin
            dec_q <= dec;
            a_q   <= op_a;
            b_q   <= op_b;
        end
    end

    assign alu_b = dec_q.use_imm ? dec_q.imm : b_q;

    always_comb begin
        case (dec_q.alu_op)
            alu_add:  alu_out = a_q + alu_b;
            alu_sub:  alu_out = a_q - alu_b;
            alu_slt:  alu_out = {31'd0, $signed(a_q) < $signed(alu_b)};
            alu_sltu: alu_out = {31'd0, a_q < alu_b};
            alu_xor:  alu_out = a_q ^ alu_b;
            alu_or:   alu_out = a_q | alu_b;
            alu_and:  alu_out = a_q & alu_b;
            alu_sll:  alu_out = a_q << alu_b[4:0];
            alu_srl:  alu_out = a_q >> alu_b[4:0];
            alu_sra:  alu_out = $unsigned($signed(a_q) >>> alu_b[4:0]);
            default:  alu_out = alu_b;
        endcase
    end

    // branch condition by funct3
    always_comb begin
        case (dec_q.funct3)
            3'b000:  taken = (a_q == b_q);
            3'b001:  taken = (a_q != b_q);
            3'b100:  taken = $signed(a_q) < $signed(b_q);
            3'b101:  taken = $signed(a_q) >= $signed(b_q);
            3'b110:  taken = a_q < b_q;
            default: taken = a_q >= b_q;
        endcase
    end

    assign redirect = dec_q.valid &&
                      ((dec_q.opcode == op_jal) || ((dec_q.opcode == op_branch) && taken));
    assign redirect_pc = dec_q.pc + dec_q.imm;

    always_comb begin
        exe_comb.valid    = dec_q.valid;
        exe_comb.pc       = dec_q.pc;
        exe_comb.instr    = dec_q.instr;
        exe_comb.rd       = dec_q.rd;
        exe_comb.rd_write = dec_q.rd_write;
        // jal links the return address
        exe_comb.result   = (dec_q.opcode == op_jal) ? dec_q.pc + instr_step : alu_out;
        exe_comb.next_pc  = redirect ? redirect_pc : dec_q.pc + instr_step;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_q <= '0;
        end else if (instr_valid) begin
            exe_q <= exe_comb;
        end
    end

endmodule

/* rv_pkg.sv */
package rv_pkg;

    // data and address width
    localparam int xlen = 32;
    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // sequential step between instruction words
    localparam logic [xlen-1:0] instr_step = 32'd4;

    // major opcodes, encoded as the rv32i opcode field
    typedef enum logic [6:0] {
        op_none   = 7'b0000000,
        op_lui    = 7'b0110111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    // decoded control, decode to execute
    typedef struct packed {
        logic            valid;
        opcode_e         opcode;
        alu_op_e         alu_op;
        // operand b comes from imm
        logic            use_imm;
        // branch condition select
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic            rd_write;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
    } dec_ctrl_t;

    // execute stage register, also the forwarding record
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic            rd_write;
        logic [xlen-1:0] result;
        logic [xlen-1:0] next_pc;
    } exe_out_t;

    // retired instruction seen at the core boundary
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic            rd_write;
        logic [xlen-1:0] rd_wdata;
    } commit_t;

endpackage

/* rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic            wr_en,
    input  logic [4:0]      wr_addr,
    input  logic [xlen-1:0] wr_data,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    logic [xlen-1:0] regs [32];

    // single write port, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, x0 hardwired
    always_comb begin
        rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
        rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    end

endmodule

/* rv_result.sv */
`timescale 1ns/100ps

module rv_result import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  exe_out_t        exe_q,
    output logic            wr_en,
    output logic [4:0]      wr_addr,
    output logic [xlen-1:0] wr_data,
    output exe_out_t        res_fwd,
    output logic            commit_valid,
    output commit_t         commit
);

    logic halted;
    logic retire;
    logic rd_live;

    // retire only on advancing cycles, nothing after a self loop
    assign retire  = exe_q.valid && instr_valid && !halted;
    assign rd_live = exe_q.rd_write && (exe_q.rd != 5'd0);

    // sticky once a jump to itself retires
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (retire && (exe_q.next_pc == exe_q.pc)) begin
            halted <= 1'b1;
        end
    end

    assign wr_en   = retire && rd_live;
    assign wr_addr = exe_q.rd;
    assign wr_data = exe_q.result;

    // write-back value seen by decode, two older
    always_comb begin
        res_fwd       = exe_q;
        res_fwd.valid = exe_q.valid && !halted;
    end

    assign commit_valid = retire;

    always_comb begin
        commit.pc       = exe_q.pc;
        commit.next_pc  = exe_q.next_pc;
        commit.instr    = exe_q.instr;
        commit.rd       = exe_q.rd;
        commit.rd_write = exe_q.rd_write;
        // x0 and no-write slots report zero
        commit.rd_wdata = rd_live ? exe_q.result : '0;
    end

endmodule

/* rv_stimulus.txt */
# program words as P address word
# expected commits in order as C pc next_pc rd wdata
P 00000000 800000B7
P 00000004 FFB00113
P 00000008 0040D193
P 0000000C 00312233
P 00000010 003132B3
P 00000014 4040D333
P 00000018 00130013
P 0000001C 406003B3
P 00000020 00520463
P 00000024 00521463
P 00000028 7FF00413
P 0000002C 008004EF
P 00000030 05504513
P 00000034 0F04F513
P 00000038 0000006F
C 00000000 00000004 01 80000000
C 00000004 00000008 02 FFFFFFFB
C 00000008 0000000C 03 08000000
C 0000000C 00000010 04 00000001
C 00000010 00000014 05 00000000
C 00000014 00000018 06 C0000000
C 00000018 0000001C 00 00000000
C 0000001C 00000020 07 40000000
C 00000020 00000024 00 00000000
C 00000024 0000002C 00 00000000
C 0000002C 00000034 09 00000030
C 00000034 00000038 0A 00000030
C 00000038 00000038 00 00000000

/* tb.f */
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_tb.sv
